/* sources.f */
busPkg.sv
smapPkg.sv
busSlave.sv
smapSequencer.sv
smapHost.sv
smapHostAssert.sv
smapHostTb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module smapHostTb -o smapHostSim &&
./obj_dir/smapHostSim | tee /dev/stderr | grep -qx "sim passed" &&
echo "run.sh: test ok" ||
{ echo "run.sh: test not ok"; exit 1; }

/* smapHostTb.sv */
//--------------------
// SelectMAP host testbench
// Bus host tasks and a byte-serial device model
//--------------------
`timescale 1ns/1ps

module smapHostTb
   import busPkg::*, smapPkg::*;
();

   localparam int unsigned wordBytes = 4;
   localparam int          ackTimeout = 200;   // Cycles per handshake phase

   logic        Bus2IP_Clk;
   logic        rstN;
   busReqT      busReq;
   busRspT      busRsp;
   smapInT      smapIn;
   smapOutT     smapOut;
   logic [31:0] readWord;    // Word the device returns
   logic        devInitB;
   logic        devDone;
   int unsigned byteIdx;     // Byte the device presents next

   smapHost #(.wordBytes(wordBytes)) smapHost_i
   (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rstN       (rstN),
      .busReq     (busReq),
      .busRsp     (busRsp),
      .smapIn     (smapIn),
      .smapOut    (smapOut)
   );

   bind smapHost smapHostAssert #(.wordBytes(wordBytes)) smapHostAssert_i (.*);

   initial
   begin
      Bus2IP_Clk = 1'b0;
      forever #20 Bus2IP_Clk = ~Bus2IP_Clk;   // 40 ns
   end

   //--------------------
   // Device model
   //--------------------
   // Next byte after each CCLK rise of a read, back to byte 0 while CS_B is high
   always @(negedge Bus2IP_Clk)
   begin
      if (smapOut.csB)
         byteIdx = 0;
      else if (smapOut.cclk && smapOut.rdwrB && byteIdx < wordBytes - 1)
         byteIdx = byteIdx + 1;
   end

   assign smapIn.dIn   = readWord[8*(wordBytes-1-byteIdx) +: 8];
   assign smapIn.initB = devInitB;
   assign smapIn.done  = devDone;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run stopped");
   endtask

   // Bound checker failures end the run at the next falling edge
   always @(negedge Bus2IP_Clk)
   begin
      if (smapHost_i.smapHostAssert_i.failCnt != 0)
         failRun("Assertion failure reported by the checker");
   end

   // Wait on falling edges until ack has the given level
   task automatic waitAck(input logic level);
      int cnt;
      cnt = 0;
      while (busRsp.ack !== level)
      begin
         @(negedge Bus2IP_Clk);
         cnt++;
         if (cnt > ackTimeout)
            failRun($sformatf("Timeout at %0t waiting for ack to become %0b", $time, level));
      end
   endtask

   // One complete four-phase access
   task automatic busAccess(input logic wr, input regSelE sel, input logic [31:0] wdata);
      int unsigned holdCycles;
      @(negedge Bus2IP_Clk);
      busReq.wr    = wr;
      busReq.sel   = sel;
      busReq.wdata = wdata;
      busReq.req   = 1'b1;
      waitAck(1'b1);
      holdCycles = $urandom_range(3, 1);   // Req stays up a while after ack
      repeat (holdCycles) @(negedge Bus2IP_Clk);
      busReq.req = 1'b0;            // Return to zero
      waitAck(1'b0);
   endtask

   //--------------------
   // Stimulus
   //--------------------
   initial
   begin
      void'($urandom(94));
      busReq   = '0;
      readWord = '0;
      devInitB = 1'b1;
      devDone  = 1'b0;
      byteIdx  = 0;
      rstN     = 1'b0;
      repeat (3) @(posedge Bus2IP_Clk);
      @(negedge Bus2IP_Clk);
      rstN = 1'b1;
      repeat (6) @(negedge Bus2IP_Clk);   // Idle pins after reset

      busAccess(1'b0, regCtrl, 32'd0);
      busAccess(1'b1, regCtrl, 32'h0000_0000);   // PROG_B low
      busAccess(1'b0, regCtrl, 32'd0);
      devInitB = 1'b0;
      devDone  = 1'b1;
      repeat (3) @(negedge Bus2IP_Clk);
      busAccess(1'b0, regCtrl, 32'd0);
      busAccess(1'b1, regCtrl, 32'h0000_0004);   // PROG_B back high
      busAccess(1'b0, regCtrl, 32'd0);

      for (int i = 0; i < 4; i++)
      begin
         busAccess(1'b1, regData, $urandom);
         readWord = $urandom;
         busAccess(1'b0, regData, 32'd0);
      end

      repeat (4) @(negedge Bus2IP_Clk);
      if (smapHost_i.smapHostAssert_i.failCnt == 0)
      begin
         $display("sim passed");
         $finish;
      end
      else
         failRun("Assertion failure reported by the checker");
   end

endmodule

/* smapHostAssert.sv */
//--------------------
// SelectMAP host checker, bound to the top level
// Bus handshake, control bits and pin sequences
//--------------------
`timescale 1ns/1ps

module smapHostAssert
   import busPkg::*, smapPkg::*;
#(
   parameter int unsigned wordBytes = 4
)
(
   input logic    Bus2IP_Clk,
   input logic    rstN,
   input busReqT  busReq,
   input busRspT  busRsp,
   input smapInT  smapIn,
   input smapOutT smapOut
);

   int unsigned            failCnt = 0; // Failed assertions so far
   logic                   seenReqQ;    // A request has been made
   int unsigned            riseCntQ;    // CCLK rises with CS_B low
   logic [8*wordBytes-1:0] rdExpQ;      // Bytes seen on D during a read
   logic [1:0]             progBWrQ;    // Write data PROG_B bit, two cycles of history
   logic                   xferRise;    // CCLK rises at this edge, CS_B low
   logic [7:0]             wrExp;       // Byte due on D at this rise
   logic [31:0]            ctrlExp;     // Control word from the pins

   assign xferRise = !smapOut.cclk && !smapOut.csB;
   assign wrExp    = busReq.wdata[8*(wordBytes-1-riseCntQ) +: 8];
   assign ctrlExp  = {29'd0, smapOut.progB, smapIn.initB, smapIn.done};

   always_ff @(posedge Bus2IP_Clk)
   begin
      if (!rstN)
      begin
         seenReqQ <= 1'b0;
         riseCntQ <= 0;
         rdExpQ   <= '0;
         progBWrQ <= '1;
      end
      else
      begin
         if (busReq.req)
            seenReqQ <= 1'b1;
         progBWrQ <= {progBWrQ[0], busReq.wdata[CtrlProgBBit]};
         if (smapOut.csB)
            riseCntQ <= 0;                         // Cleared between words
         else if (xferRise)
            riseCntQ <= riseCntQ + 1;
         if (xferRise && smapOut.rdwrB)
            rdExpQ <= (rdExpQ << 8) | (8*wordBytes)'(smapIn.dIn);   // MSB first
      end
   end

   //--------------------
   // Idle pins after reset
   //--------------------
   resetIdle: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      !seenReqQ |-> smapOut.csB && smapOut.progB && smapOut.rdwrB
                    && smapOut.dTri == 8'hFF && !busRsp.ack)
      else
      begin
         failCnt++;
         $error("pins not idle or ack high before the first request");
      end
   cclkToggle: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $past(rstN) |-> smapOut.cclk != $past(smapOut.cclk))
      else
      begin
         failCnt++;
         $error("CCLK did not toggle");
      end

   // Handshake
   ackNeedsReq: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $rose(busRsp.ack) |-> $past(busReq.req))
      else
      begin
         failCnt++;
         $error("ack rose without req");
      end
   ackHolds: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      busRsp.ack && busReq.req |=> busRsp.ack)
      else
      begin
         failCnt++;
         $error("ack fell while req high");
      end
   noXferInAck: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      busRsp.ack |-> smapOut.csB)
      else
      begin
         failCnt++;
         $error("transfer active while ack high");
      end

   //--------------------
   // Control register
   //--------------------
   ctrlWrite: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $rose(busRsp.ack) && $past(busReq.req && busReq.wr && busReq.sel == regCtrl)
      |=> smapOut.progB == progBWrQ[1])
      else
      begin
         failCnt++;
         $error("%0t smapOut.progB expected %b got %b", $time, $sampled(progBWrQ[1]),
                $sampled(smapOut.progB));
      end
   ctrlRead: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $rose(busRsp.ack) && $past(busReq.req && !busReq.wr && busReq.sel == regCtrl)
      |-> busRsp.rdata == ctrlExp)
      else
      begin
         failCnt++;
         $error("%0t busRsp.rdata expected %h got %h", $time, $sampled(ctrlExp),
                $sampled(busRsp.rdata));
      end

   // Data write, one byte per CCLK rise, MSB first
   wrByte: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      xferRise && !smapOut.rdwrB && riseCntQ < wordBytes |-> smapOut.dOut == wrExp)
      else
      begin
         failCnt++;
         $error("%0t smapOut.dOut expected %h got %h", $time, $sampled(wrExp),
                $sampled(smapOut.dOut));
      end
   wrTri: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      xferRise && !smapOut.rdwrB |-> smapOut.dTri == 8'h00)
      else
      begin
         failCnt++;
         $error("%0t smapOut.dTri expected 00 got %h", $time, $sampled(smapOut.dTri));
      end
   byteCount: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $rose(smapOut.csB) |-> riseCntQ == wordBytes)
      else
      begin
         failCnt++;
         $error("%0t riseCntQ expected %0d got %0d", $time, wordBytes,
                $sampled(riseCntQ));
      end

   // Data read
   rdTri: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      smapOut.rdwrB |-> smapOut.dTri == 8'hFF)
      else
      begin
         failCnt++;
         $error("%0t smapOut.dTri expected ff got %h", $time, $sampled(smapOut.dTri));
      end
   rdData: assert property (@(posedge Bus2IP_Clk) disable iff (!rstN)
      $rose(busRsp.ack) && $past(busReq.req && !busReq.wr && busReq.sel == regData)
      |-> busRsp.rdata == 32'(rdExpQ))
      else
      begin
         failCnt++;
         $error("%0t busRsp.rdata expected %h got %h", $time, 32'($sampled(rdExpQ)),
                $sampled(busRsp.rdata));
      end

endmodule

/* smapHost.sv */
//------------------
// SelectMAP host port top level
// Bus slave in front of the byte sequencer
//------------------
`timescale 1ns/1ps

module smapHost
   import busPkg::*, smapPkg::*;
#(
   parameter int unsigned wordBytes = 4   // Bytes per data word, 1 to 4
)
(
   input  logic    Bus2IP_Clk,
   input  logic    rstN,
   input  busReqT  busReq,    // Host request
   output busRspT  busRsp,    // Host response
   input  smapInT  smapIn,    // Device pins in
   output smapOutT smapOut    // Device pins out
);

   //------------------
   // Command handshake
   //------------------
   logic                   cmdReq;
   smapOpE                 cmdOp;
   logic [8*wordBytes-1:0] cmdData;   // Write word
   logic                   cmdAck;
   logic [8*wordBytes-1:0] rdWord;    // Read word, valid with cmdAck

   // Status and PROG_B between the two halves
   logic initB;
   logic done;
   logic progB;

   busSlave #(.wordBytes(wordBytes)) busSlave_i
   (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rstN       (rstN),
      .busReq     (busReq),
      .busRsp     (busRsp),
      .cmdReq     (cmdReq),
      .cmdOp      (cmdOp),
      .cmdData    (cmdData),
      .cmdAck     (cmdAck),
      .rdWord     (rdWord),
      .initB      (initB),
      .done       (done),
      .progB      (progB)
   );

   smapSequencer #(.wordBytes(wordBytes)) smapSequencer_i
   (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rstN       (rstN),
      .cmdReq     (cmdReq),
      .cmdOp      (cmdOp),
      .cmdData    (cmdData),
      .cmdAck     (cmdAck),
      .rdWord     (rdWord),
      .initB      (initB),
      .done       (done),
      .progB      (progB),
      .smapIn     (smapIn),
      .smapOut    (smapOut)
   );

endmodule

/* smapSequencer.sv */
//------------------
// SelectMAP byte engine with CCLK divider
// Pad registers, byte-serial write and read
//------------------
`timescale 1ns/1ps

module smapSequencer
   import smapPkg::*;
#(
   parameter int unsigned wordBytes = 4
)
(
   input  logic                   Bus2IP_Clk,
   input  logic                   rstN,
   input  logic                   cmdReq,
   input  smapOpE                 cmdOp,
   input  logic [8*wordBytes-1:0] cmdData,
   output logic                   cmdAck,
   output logic [8*wordBytes-1:0] rdWord,
   output logic                   initB,     // Registered INIT_B
   output logic                   done,      // Registered DONE
   input  logic                   progB,
   input  smapInT                 smapIn,
   output smapOutT                smapOut
);

   localparam int unsigned WordW = 8 * wordBytes;

   smapStateE        stateQ;
   smapOpE           opQ;        // Latched command
   logic [2:0]       byteCntQ;   // CCLK rises in stXfer
   logic             sampleQ;    // Cycle after a rise in stXfer
   logic             cmdAckQ;
   logic [WordW-1:0] wrShiftQ;   // Top byte goes out next
   logic [WordW-1:0] rdShiftQ;   // Bytes shift in from the bottom
   smapInT           smapInQ;    // Input pad flops
   smapOutT          smapOutQ;   // Output pad flops
   logic             riseNext;   // CCLK rises at this edge
   logic             lastByte;

   assign riseNext = !smapOutQ.cclk;
   assign lastByte = (byteCntQ == 3'(wordBytes - 1));

   //------------------
   // Control FSM
   //------------------
   always_ff @(posedge Bus2IP_Clk)
   begin
      if (!rstN)
      begin
         stateQ   <= stIdle;
         opQ      <= opWrite;
         byteCntQ <= '0;
         sampleQ  <= 1'b0;
         cmdAckQ  <= 1'b0;
      end
      else
      begin
         sampleQ <= (stateQ == stXfer) && riseNext;
         unique case (stateQ)
            stIdle:
               if (cmdReq)
               begin
                  opQ    <= cmdOp;
                  stateQ <= stAlign;
               end
            stAlign:
               if (riseNext)
                  stateQ <= stXfer;          // Pads follow one cycle later, on a fall
            stXfer:
               if (riseNext)
               begin
                  if (lastByte)
                  begin
                     byteCntQ <= '0;
                     stateQ   <= stDone;     // CS_B rises at the next fall
                  end
                  else
                     byteCntQ <= byteCntQ + 3'd1;
               end
            stDone:
               if (!cmdAckQ)
                  cmdAckQ <= 1'b1;           // Last read byte lands this edge
               else if (!cmdReq)
               begin
                  cmdAckQ <= 1'b0;
                  stateQ  <= stIdle;
               end
            default:
               stateQ <= stIdle;
         endcase
      end
   end

   //------------------
   // Data shifters
   //------------------
   always_ff @(posedge Bus2IP_Clk)
   begin
      smapInQ <= smapIn;                                   // Input pads
      if (stateQ == stIdle && cmdReq)
         wrShiftQ <= cmdData;
      else if (stateQ == stXfer && riseNext)
         wrShiftQ <= wrShiftQ << 8;                        // Next byte ready for the fall
      if (sampleQ && opQ == opRead)
         rdShiftQ <= (rdShiftQ << 8) | WordW'(smapInQ.dIn);   // MSB first
   end

   //------------------
   // Output pads
   //------------------
   always_ff @(posedge Bus2IP_Clk)
   begin
      if (!rstN)
      begin
         smapOutQ.dOut  <= '0;
         smapOutQ.dTri  <= '1;
         smapOutQ.rdwrB <= 1'b1;
         smapOutQ.csB   <= 1'b1;
         smapOutQ.progB <= 1'b1;
         smapOutQ.cclk  <= 1'b0;
      end
      else
      begin
         smapOutQ.cclk  <= ~smapOutQ.cclk;                 // Bus clock / 2
         smapOutQ.progB <= progB;
         smapOutQ.csB   <= (stateQ != stXfer);
         smapOutQ.rdwrB <= (stateQ != stXfer) || (opQ == opRead);
         // Drive D only while writing
         smapOutQ.dTri  <= (stateQ == stXfer && opQ == opWrite) ? 8'h00 : 8'hFF;
         smapOutQ.dOut  <= wrShiftQ[WordW-1 -: 8];
      end
   end

   assign smapOut = smapOutQ;
   assign cmdAck  = cmdAckQ;
   assign rdWord  = rdShiftQ;
   assign initB   = smapInQ.initB;
   assign done    = smapInQ.done;

endmodule

/* busSlave.sv */
//------------------
// Four-phase bus endpoint
// Control register, command handshake, read mux
//------------------
`timescale 1ns/1ps

module busSlave
   import busPkg::*, smapPkg::*;
#(
   parameter int unsigned wordBytes = 4
)
(
   input  logic                   Bus2IP_Clk,
   input  logic                   rstN,
   input  busReqT                 busReq,
   output busRspT                 busRsp,
   output logic                   cmdReq,    // To sequencer
   output smapOpE                 cmdOp,
   output logic [8*wordBytes-1:0] cmdData,
   input  logic                   cmdAck,    // From sequencer
   input  logic [8*wordBytes-1:0] rdWord,
   input  logic                   initB,     // Registered pin status
   input  logic                   done,
   output logic                   progB      // Control bit to PROG_B
);

   busReqT      reqQ;      // Registered host request
   logic        ackQ;
   logic        cmdReqQ;
   logic        progBQ;
   logic [31:0] rdataQ;    // Response data
   logic [31:0] ctrlWord;  // Control register read view
   logic        cmdDone;   // Sequencer finished the command

   //------------------
   // Handshake and control register
   //------------------
   assign cmdDone = cmdReqQ && cmdAck;

   always_ff @(posedge Bus2IP_Clk)
   begin
      if (!rstN)
      begin
         reqQ    <= '0;
         ackQ    <= 1'b0;
         cmdReqQ <= 1'b0;
         progBQ  <= 1'b1;                    // Device not held in reset
      end
      else
      begin
         reqQ <= busReq;                     // 1 cycle input stage
         if (!reqQ.req)
         begin
            // Return to zero, both sides
            ackQ    <= 1'b0;
            cmdReqQ <= 1'b0;
         end
         else if (!ackQ)
         begin
            if (reqQ.sel == regCtrl)
            begin
               ackQ <= 1'b1;                 // Local register, fixed latency
               if (reqQ.wr)
                  progBQ <= reqQ.wdata[CtrlProgBBit];
            end
            else if (cmdDone)
               ackQ <= 1'b1;                 // Cycle after cmdAck
            else if (!cmdAck)
               cmdReqQ <= 1'b1;              // Previous command fully closed
         end
      end
   end

   //------------------
   // Read data
   //------------------
   always_comb
   begin
      ctrlWord               = '0;
      ctrlWord[CtrlProgBBit] = progBQ;
      ctrlWord[CtrlInitBBit] = initB;
      ctrlWord[CtrlDoneBit]  = done;
   end

   // Captured in the cycle ack rises, held while ack is high
   always_ff @(posedge Bus2IP_Clk)
   begin
      if (reqQ.req && !ackQ)
      begin
         if (reqQ.sel == regCtrl)
            rdataQ <= reqQ.wr ? '0 : ctrlWord;
         else if (cmdDone)
            rdataQ <= reqQ.wr ? '0 : 32'(rdWord);   // Zero extend
      end
   end

   always_comb
   begin
      busRsp.ack   = ackQ;
      busRsp.rdata = rdataQ;
   end

   // Command fields come straight from the held request
   assign cmdReq  = cmdReqQ;
   assign cmdOp   = reqQ.wr ? opWrite : opRead;
   assign cmdData = reqQ.wdata[8*wordBytes-1:0];   // Low bytes, MSB first on pins
   assign progB   = progBQ;

endmodule

/* smapPkg.sv */
//------------------
// SelectMAP pin types, sequencer state and opcode
// Control register bit map
//------------------
package smapPkg;

   //------------------
   // Sequencer command
   //------------------
   typedef enum logic
   {
      opWrite = 1'b0,   // Bytes out on D
      opRead  = 1'b1    // Bytes in from D
   } smapOpE;

   // Byte engine states
   typedef enum logic [1:0]
   {
      stIdle  = 2'd0,   // Waiting for a command
      stAlign = 2'd1,   // Wait for CCLK low
      stXfer  = 2'd2,   // CS_B low, bytes moving
      stDone  = 2'd3    // Command ack phase
   } smapStateE;

   //------------------
   // Pins toward the device, 20 bits
   //------------------
   typedef struct packed
   {
      logic [7:0] dOut;    // D output data
      logic [7:0] dTri;    // D tristate, 1 = input
      logic       rdwrB;   // RDWR_B
      logic       csB;     // CS_B
      logic       progB;   // PROG_B
      logic       cclk;    // CCLK
   } smapOutT;

   // Pins from the device, 10 bits
   typedef struct packed
   {
      logic [7:0] dIn;     // D input data
      logic       initB;   // INIT_B
      logic       done;    // DONE
   } smapInT;

   // Control register bits
   localparam int unsigned CtrlDoneBit  = 0;
   localparam int unsigned CtrlInitBBit = 1;
   localparam int unsigned CtrlProgBBit = 2;

endpackage

/* busPkg.sv */
//------------------
// Host bus types for the SelectMAP port
// Request and response of the four-phase req/ack bus
//------------------
package busPkg;

   //------------------
   // Register select
   //------------------
   // One address bit picks the register
   typedef enum logic
   {
      regCtrl = 1'b0,   // PROG_B, INIT_B, DONE
      regData = 1'b1    // Word to or from the SelectMAP pins
   } regSelE;

   //------------------
   // Host request, 35 bits
   //------------------
   // Held stable by the host from req rise until ack
   typedef struct packed
   {
      logic        req;     // Four-phase request
      logic        wr;      // 1 write, 0 read
      regSelE      sel;     // Addressed register
      logic [31:0] wdata;   // Write data
   } busReqT;

   //------------------
   // Slave response, 33 bits
   //------------------
   typedef struct packed
   {
      logic        ack;     // High until req falls
      logic [31:0] rdata;   // Valid while ack is high
   } busRspT;

endpackage
